// File: Makefile
TOP = game_control_tb
LOG = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --top-module game_control_top \
		rtl/game_pkg.sv rtl/ctrl_msg_if.sv rtl/game_state_reg.sv \
		rtl/advance_handler.sv rtl/init_draw_handler.sv rtl/move_handler.sv \
		rtl/turn_handler.sv rtl/ctrl_arbiter.sv rtl/game_control_top.sv

sim:
	verilator --binary --timing --top-module $(TOP) -f game_control_top.f -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q -F "*** TEST PASSED ***" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: game_control_top.f
rtl/game_pkg.sv
rtl/ctrl_msg_if.sv
rtl/game_state_reg.sv
rtl/advance_handler.sv
rtl/init_draw_handler.sv
rtl/move_handler.sv
rtl/turn_handler.sv
rtl/ctrl_arbiter.sv
rtl/game_control_top.sv
testbench/clock_gen.sv
testbench/game_control_tb.sv

// File: rtl/advance_handler.sv
`timescale 1ns/100ps

module advance_handler #(
    parameter int PLAYER = game_pkg::P1
) (
    input  logic clk,
    input  logic reset_table,
    input  game_pkg::game_state_t state,
    input  logic start_game,
    input  logic inter_ready,
    input  logic interboard_en,
    input  logic [game_pkg::MSG_W-1:0] interboard_msg_type,
    output logic advance_state,
    ctrl_msg_if.source adv_msg
);

    logic pending;
    logic sent;
    logic rx_start;

    // p2 just follows the start message of the other board
    assign rx_start = PLAYER == game_pkg::P2 && state == game_pkg::INIT
                      && interboard_en && interboard_msg_type == game_pkg::MSG_START;
    assign advance_state = sent || rx_start;

    always_ff @(posedge clk) begin
        adv_msg.en <= 1'b0;
        adv_msg.move_dir <= 1'b0;
        adv_msg.block_x <= '0;
        adv_msg.block_y <= '0;
        adv_msg.msg_type <= game_pkg::MSG_NONE;
        adv_msg.card <= '0;
        adv_msg.sel_len <= '0;
        sent <= 1'b0;
        if (reset_table || state != game_pkg::INIT) begin
            pending <= 1'b0;
        end else if (pending && inter_ready) begin
            pending <= 1'b0;
            sent <= 1'b1;
            adv_msg.en <= 1'b1;
            adv_msg.msg_type <= game_pkg::MSG_START;
        end else if (PLAYER == game_pkg::P1 && start_game) begin
            pending <= 1'b1;
        end
    end

endmodule

// File: rtl/ctrl_arbiter.sv
`timescale 1ns/100ps

module ctrl_arbiter (
    input  game_pkg::game_state_t state,
    ctrl_msg_if.sink adv_msg,
    ctrl_msg_if.sink deal_msg,
    ctrl_msg_if.sink move_msg,
    ctrl_msg_if.sink turn_msg,
    output logic ctrl_en,
    output logic ctrl_move_dir,
    output logic [game_pkg::BLOCK_X_W-1:0] ctrl_block_x,
    output logic [game_pkg::BLOCK_Y_W-1:0] ctrl_block_y,
    output logic [game_pkg::MSG_W-1:0] ctrl_msg_type,
    output logic [game_pkg::CARD_W-1:0] ctrl_card,
    output logic [game_pkg::SEL_LEN_W-1:0] ctrl_sel_len
);

    // whole message flattened, en in the top bit
    typedef logic [1 + 1 + game_pkg::BLOCK_X_W + game_pkg::BLOCK_Y_W + game_pkg::MSG_W
                   + game_pkg::CARD_W + game_pkg::SEL_LEN_W - 1:0] msg_vec_t;

    msg_vec_t adv_v;
    msg_vec_t deal_v;
    msg_vec_t move_v;
    msg_vec_t turn_v;
    msg_vec_t sel_v;

    assign adv_v = {adv_msg.en, adv_msg.move_dir, adv_msg.block_x, adv_msg.block_y,
                    adv_msg.msg_type, adv_msg.card, adv_msg.sel_len};
    assign deal_v = {deal_msg.en, deal_msg.move_dir, deal_msg.block_x, deal_msg.block_y,
                     deal_msg.msg_type, deal_msg.card, deal_msg.sel_len};
    assign move_v = {move_msg.en, move_msg.move_dir, move_msg.block_x, move_msg.block_y,
                     move_msg.msg_type, move_msg.card, move_msg.sel_len};
    assign turn_v = {turn_msg.en, turn_msg.move_dir, turn_msg.block_x, turn_msg.block_y,
                     turn_msg.msg_type, turn_msg.card, turn_msg.sel_len};

    // state decides the owner of the link
    always_comb begin
        case (state)
            game_pkg::INIT:
                sel_v = adv_v;
            game_pkg::P1_INIT_DRAW, game_pkg::P2_INIT_DRAW:
                sel_v = deal_v;
            game_pkg::P1_MOVE, game_pkg::P2_MOVE:
                sel_v = move_v;
            game_pkg::P1_WAIT_IN, game_pkg::P2_WAIT_IN:
                sel_v = turn_v;
            default:
                sel_v = '0;
        endcase
    end

    assign {ctrl_en, ctrl_move_dir, ctrl_block_x, ctrl_block_y,
            ctrl_msg_type, ctrl_card, ctrl_sel_len} = sel_v;

endmodule

// File: rtl/ctrl_msg_if.sv
`timescale 1ns/100ps

// one outgoing control message toward the interboard link
interface ctrl_msg_if;

    logic en;
    logic move_dir;
    logic [game_pkg::BLOCK_X_W-1:0] block_x;
    logic [game_pkg::BLOCK_Y_W-1:0] block_y;
    logic [game_pkg::MSG_W-1:0] msg_type;
    logic [game_pkg::CARD_W-1:0] card;
    logic [game_pkg::SEL_LEN_W-1:0] sel_len;

    modport source (
        output en, move_dir, block_x, block_y, msg_type, card, sel_len
    );

    modport sink (
        input en, move_dir, block_x, block_y, msg_type, card, sel_len
    );

endinterface

// File: rtl/game_control_top.sv
`timescale 1ns/100ps

module game_control_top #(
    parameter int PLAYER = game_pkg::P1
) (
    input  logic clk,
    input  logic reset_table,
    input  logic start_game,
    input  logic done_and_next,
    input  logic draw_and_next,
    input  logic inter_ready,
    input  logic interboard_en,
    input  logic [game_pkg::MSG_W-1:0] interboard_msg_type,
    input  logic l_click,
    input  logic mouse_inblock,
    input  logic [game_pkg::BLOCK_X_W-1:0] mouse_block_x,
    input  logic [game_pkg::BLOCK_Y_W-1:0] mouse_block_y,
    input  logic [game_pkg::MAP_W-1:0] map,
    output logic can_done,
    output logic can_draw,
    output logic transmit,
    output logic ctrl_en,
    output logic ctrl_move_dir,
    output logic [game_pkg::BLOCK_X_W-1:0] ctrl_block_x,
    output logic [game_pkg::BLOCK_Y_W-1:0] ctrl_block_y,
    output logic [game_pkg::MSG_W-1:0] ctrl_msg_type,
    output logic [game_pkg::CARD_W-1:0] ctrl_card,
    output logic [game_pkg::SEL_LEN_W-1:0] ctrl_sel_len,
    output logic [game_pkg::SEL_W-1:0] sel_card
);

    game_pkg::game_state_t state;
    logic my_turn;
    logic advance_state;
    logic init_draw_done;
    logic move_done;
    logic switch_turn;

    // one message channel per handler
    ctrl_msg_if adv_msg();
    ctrl_msg_if deal_msg();
    ctrl_msg_if move_msg();
    ctrl_msg_if turn_msg();

    game_state_reg #(.PLAYER(PLAYER)) u_state (
        .clk, .reset_table, .advance_state, .init_draw_done, .move_done, .switch_turn,
        .l_click, .mouse_inblock, .interboard_en, .interboard_msg_type,
        .state, .my_turn, .transmit
    );

    advance_handler #(.PLAYER(PLAYER)) u_advance (
        .clk, .reset_table, .state, .start_game, .inter_ready, .interboard_en,
        .interboard_msg_type, .advance_state, .adv_msg(adv_msg.source)
    );

    init_draw_handler u_init_draw (
        .clk, .reset_table, .state, .my_turn, .inter_ready, .init_draw_done,
        .deal_msg(deal_msg.source)
    );

    move_handler u_move (
        .clk, .reset_table, .state, .my_turn, .inter_ready, .l_click, .mouse_inblock,
        .mouse_block_x, .mouse_block_y, .map, .move_done, .sel_card,
        .move_msg(move_msg.source)
    );

    turn_handler u_turn (
        .clk, .reset_table, .state, .my_turn, .inter_ready, .move_done, .done_and_next,
        .draw_and_next, .interboard_en, .interboard_msg_type, .can_done, .can_draw,
        .switch_turn, .turn_msg(turn_msg.source)
    );

    ctrl_arbiter u_arbiter (
        .state, .adv_msg(adv_msg.sink), .deal_msg(deal_msg.sink),
        .move_msg(move_msg.sink), .turn_msg(turn_msg.sink),
        .ctrl_en, .ctrl_move_dir, .ctrl_block_x, .ctrl_block_y, .ctrl_msg_type,
        .ctrl_card, .ctrl_sel_len
    );

endmodule

// File: rtl/game_pkg.sv
package game_pkg;

    // game flow as seen by one board
    typedef enum logic [2:0] {
        INIT,
        P1_INIT_DRAW,
        P2_INIT_DRAW,
        P1_WAIT_IN,
        P2_WAIT_IN,
        P1_MOVE,
        P2_MOVE
    } game_state_t;

    // which board this design is
    localparam int P1 = 0;
    localparam int P2 = 1;

    // interboard message codes
    localparam int MSG_W = 4;
    localparam logic [MSG_W-1:0] MSG_NONE = 4'd0;
    localparam logic [MSG_W-1:0] MSG_START = 4'd1;
    localparam logic [MSG_W-1:0] MSG_DRAW = 4'd2;
    localparam logic [MSG_W-1:0] MSG_STATE_TURN = 4'd3;
    localparam logic [MSG_W-1:0] MSG_TAKE = 4'd4;
    localparam logic [MSG_W-1:0] MSG_DOWN = 4'd5;
    localparam logic [MSG_W-1:0] MSG_DONE = 4'd6;

    // board map geometry
    localparam int GRID_COLS = 18;
    localparam int GRID_ROWS = 8;
    localparam int BLOCK_X_W = 5;
    localparam int BLOCK_Y_W = 3;
    localparam int CARD_W = 6;
    // packed row by row, index = y * GRID_COLS + x
    localparam int MAP_W = GRID_COLS * GRID_ROWS * CARD_W;
    localparam int SEL_W = GRID_COLS * GRID_ROWS;
    localparam int SEL_LEN_W = 3;

    // cards dealt to each board at game start
    localparam int INIT_HAND_SIZE = 14;

endpackage

// File: rtl/game_state_reg.sv
`timescale 1ns/100ps

module game_state_reg #(
    parameter int PLAYER = game_pkg::P1
) (
    input  logic clk,
    input  logic reset_table,
    input  logic advance_state,
    input  logic init_draw_done,
    input  logic move_done,
    input  logic switch_turn,
    input  logic l_click,
    input  logic mouse_inblock,
    input  logic interboard_en,
    input  logic [game_pkg::MSG_W-1:0] interboard_msg_type,
    output game_pkg::game_state_t state,
    output logic my_turn,
    output logic transmit
);

    game_pkg::game_state_t next_state;
    logic deal_over;
    logic start_move;

    // either our own deal finished or the other board says its deal is over
    assign deal_over = init_draw_done
                       || (interboard_en && interboard_msg_type == game_pkg::MSG_STATE_TURN);
    // clicks only count while we own the wait state
    assign start_move = my_turn && l_click && mouse_inblock;

    always_ff @(posedge clk) begin
        if (reset_table) begin
            state <= game_pkg::INIT;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            game_pkg::INIT:
                if (advance_state)
                    next_state = game_pkg::P1_INIT_DRAW;
            game_pkg::P1_INIT_DRAW:
                if (deal_over)
                    next_state = game_pkg::P2_INIT_DRAW;
            game_pkg::P2_INIT_DRAW:
                if (deal_over)
                    next_state = game_pkg::P1_WAIT_IN;
            game_pkg::P1_WAIT_IN:
                if (start_move)
                    next_state = game_pkg::P1_MOVE;
                else if (switch_turn)
                    next_state = game_pkg::P2_WAIT_IN;
            game_pkg::P2_WAIT_IN:
                if (start_move)
                    next_state = game_pkg::P2_MOVE;
                else if (switch_turn)
                    next_state = game_pkg::P1_WAIT_IN;
            game_pkg::P1_MOVE:
                if (move_done)
                    next_state = game_pkg::P1_WAIT_IN;
            game_pkg::P2_MOVE:
                if (move_done)
                    next_state = game_pkg::P2_WAIT_IN;
            default:
                next_state = game_pkg::INIT;
        endcase
    end

    // turn ownership per state
    always_comb begin
        case (state)
            game_pkg::P1_INIT_DRAW, game_pkg::P1_WAIT_IN, game_pkg::P1_MOVE:
                my_turn = PLAYER == game_pkg::P1;
            game_pkg::P2_INIT_DRAW, game_pkg::P2_WAIT_IN, game_pkg::P2_MOVE:
                my_turn = PLAYER == game_pkg::P2;
            default:
                my_turn = 1'b0;
        endcase
    end

    // p1 also talks first during start agreement
    assign transmit = my_turn || (PLAYER == game_pkg::P1 && state == game_pkg::INIT);

endmodule

// File: rtl/init_draw_handler.sv
`timescale 1ns/100ps

module init_draw_handler (
    input  logic clk,
    input  logic reset_table,
    input  game_pkg::game_state_t state,
    input  logic my_turn,
    input  logic inter_ready,
    output logic init_draw_done,
    ctrl_msg_if.source deal_msg
);

    // counts draws, then one more slot for the hand-off message
    logic [$clog2(game_pkg::INIT_HAND_SIZE + 2)-1:0] cnt;
    logic dealing;

    assign dealing = my_turn
                     && (state == game_pkg::P1_INIT_DRAW || state == game_pkg::P2_INIT_DRAW);

    always_ff @(posedge clk) begin
        deal_msg.en <= 1'b0;
        deal_msg.move_dir <= 1'b0;
        deal_msg.block_x <= '0;
        deal_msg.block_y <= '0;
        deal_msg.msg_type <= game_pkg::MSG_NONE;
        deal_msg.card <= '0;
        deal_msg.sel_len <= '0;
        init_draw_done <= 1'b0;
        if (reset_table || !dealing) begin
            cnt <= '0;
        end else if (inter_ready && cnt <= game_pkg::INIT_HAND_SIZE) begin
            cnt <= cnt + 1'b1;
            deal_msg.en <= 1'b1;
            if (cnt < game_pkg::INIT_HAND_SIZE) begin
                deal_msg.msg_type <= game_pkg::MSG_DRAW;
                deal_msg.sel_len <= game_pkg::SEL_LEN_W'(1);
            end else begin
                // last slot hands the deal over
                deal_msg.msg_type <= game_pkg::MSG_STATE_TURN;
                init_draw_done <= 1'b1;
            end
        end
    end

endmodule

// File: rtl/move_handler.sv
`timescale 1ns/100ps

module move_handler (
    input  logic clk,
    input  logic reset_table,
    input  game_pkg::game_state_t state,
    input  logic my_turn,
    input  logic inter_ready,
    input  logic l_click,
    input  logic mouse_inblock,
    input  logic [game_pkg::BLOCK_X_W-1:0] mouse_block_x,
    input  logic [game_pkg::BLOCK_Y_W-1:0] mouse_block_y,
    input  logic [game_pkg::MAP_W-1:0] map,
    output logic move_done,
    output logic [game_pkg::SEL_W-1:0] sel_card,
    ctrl_msg_if.source move_msg
);

    logic [game_pkg::BLOCK_X_W-1:0] hold_x;
    logic [game_pkg::BLOCK_Y_W-1:0] hold_y;
    logic [game_pkg::CARD_W-1:0] held_card;
    logic taken;
    logic down_pend;
    logic in_wait;
    logic in_move;
    int unsigned idx;

    assign in_wait = state == game_pkg::P1_WAIT_IN || state == game_pkg::P2_WAIT_IN;
    assign in_move = my_turn && (state == game_pkg::P1_MOVE || state == game_pkg::P2_MOVE);
    assign idx = hold_y * game_pkg::GRID_COLS + hold_x;

    always_ff @(posedge clk) begin
        move_msg.en <= 1'b0;
        move_msg.move_dir <= 1'b0;
        move_msg.block_x <= '0;
        move_msg.block_y <= '0;
        move_msg.msg_type <= game_pkg::MSG_NONE;
        move_msg.card <= '0;
        move_msg.sel_len <= '0;
        move_done <= 1'b0;
        if (reset_table || !in_move) begin
            taken <= 1'b0;
            down_pend <= 1'b0;
            sel_card <= '0;
            // tracks the mouse so the starting click's block is kept on entry
            if (in_wait) begin
                hold_x <= mouse_block_x;
                hold_y <= mouse_block_y;
            end
        end else if (!taken) begin
            if (inter_ready) begin
                taken <= 1'b1;
                held_card <= map[idx*game_pkg::CARD_W +: game_pkg::CARD_W];
                sel_card[idx] <= 1'b1;
                move_msg.en <= 1'b1;
                move_msg.block_x <= hold_x;
                move_msg.block_y <= hold_y;
                move_msg.msg_type <= game_pkg::MSG_TAKE;
                move_msg.card <= map[idx*game_pkg::CARD_W +: game_pkg::CARD_W];
                move_msg.sel_len <= game_pkg::SEL_LEN_W'(1);
            end
        end else if (down_pend) begin
            if (inter_ready) begin
                down_pend <= 1'b0;
                sel_card <= '0;
                move_done <= 1'b1;
                move_msg.en <= 1'b1;
                move_msg.move_dir <= 1'b1;
                move_msg.block_x <= hold_x;
                move_msg.block_y <= hold_y;
                move_msg.msg_type <= game_pkg::MSG_DOWN;
                move_msg.card <= held_card;
                move_msg.sel_len <= game_pkg::SEL_LEN_W'(1);
            end
        end else if (l_click && mouse_inblock) begin
            // target block of the drop
            down_pend <= 1'b1;
            hold_x <= mouse_block_x;
            hold_y <= mouse_block_y;
        end
    end

endmodule

// File: rtl/turn_handler.sv
`timescale 1ns/100ps

module turn_handler (
    input  logic clk,
    input  logic reset_table,
    input  game_pkg::game_state_t state,
    input  logic my_turn,
    input  logic inter_ready,
    input  logic move_done,
    input  logic done_and_next,
    input  logic draw_and_next,
    input  logic interboard_en,
    input  logic [game_pkg::MSG_W-1:0] interboard_msg_type,
    output logic can_done,
    output logic can_draw,
    output logic switch_turn,
    ctrl_msg_if.source turn_msg
);

    logic moved;
    logic in_wait;
    logic owned_wait;
    logic draw_pend;
    logic done_pend;
    logic done_sent;
    logic rx_done;

    assign in_wait = state == game_pkg::P1_WAIT_IN || state == game_pkg::P2_WAIT_IN;
    assign owned_wait = in_wait && my_turn;
    // a turn ends either with a move made or with a drawn card
    assign can_done = owned_wait && moved;
    assign can_draw = owned_wait && !moved;
    assign rx_done = in_wait && !my_turn && interboard_en
                     && interboard_msg_type == game_pkg::MSG_DONE;
    assign switch_turn = done_sent || rx_done;

    always_ff @(posedge clk) begin
        if (reset_table || switch_turn) begin
            moved <= 1'b0;
        end else if (move_done) begin
            moved <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        turn_msg.en <= 1'b0;
        turn_msg.move_dir <= 1'b0;
        turn_msg.block_x <= '0;
        turn_msg.block_y <= '0;
        turn_msg.msg_type <= game_pkg::MSG_NONE;
        turn_msg.card <= '0;
        turn_msg.sel_len <= '0;
        done_sent <= 1'b0;
        if (reset_table || !owned_wait) begin
            draw_pend <= 1'b0;
            done_pend <= 1'b0;
        end else if (draw_pend) begin
            // draw goes out first, done follows
            if (inter_ready) begin
                draw_pend <= 1'b0;
                done_pend <= 1'b1;
                turn_msg.en <= 1'b1;
                turn_msg.msg_type <= game_pkg::MSG_DRAW;
                turn_msg.sel_len <= game_pkg::SEL_LEN_W'(1);
            end
        end else if (done_pend) begin
            if (inter_ready) begin
                done_pend <= 1'b0;
                done_sent <= 1'b1;
                turn_msg.en <= 1'b1;
                turn_msg.msg_type <= game_pkg::MSG_DONE;
            end
        end else if (done_and_next && can_done) begin
            done_pend <= 1'b1;
        end else if (draw_and_next && can_draw) begin
            draw_pend <= 1'b1;
        end
    end

endmodule

// File: testbench/clock_gen.sv
`timescale 1ns/100ps

module clock_gen #(
    parameter int PERIOD_NS = 4,
    parameter int RESET_CYCLES = 2
) (
    output logic clk,
    output logic reset_table
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    initial begin
        reset_table <= 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        reset_table <= 1'b0;
    end

endmodule

// File: testbench/game_control_tb.sv
`timescale 1ns/100ps

module game_control_tb;

    localparam int CLK_PERIOD = 4;
    localparam int NUM_ROWS = 10;
    localparam int MAX_MSGS = 16;
    localparam int MSG_BOUND = 8;
    localparam int IDLE_CYCLES = 3;
    localparam int ROW_OVERHEAD = 10;
    localparam int VW = game_pkg::SEL_W;

    // action kinds of a table row
    localparam int K_CHECK = 0;
    localparam int K_START = 1;
    localparam int K_WAIT = 2;
    localparam int K_STATE_TURN = 3;
    localparam int K_CLICK = 4;
    localparam int K_DONE = 5;
    localparam int K_DRAW = 6;
    localparam int K_OPP_DONE = 7;

    typedef struct packed {
        logic move_dir;
        logic [game_pkg::BLOCK_X_W-1:0] block_x;
        logic [game_pkg::BLOCK_Y_W-1:0] block_y;
        logic [game_pkg::MSG_W-1:0] msg_type;
        logic [game_pkg::CARD_W-1:0] card;
        logic [game_pkg::SEL_LEN_W-1:0] sel_len;
    } msg_t;

    logic clk;
    logic reset_table;
    logic start_game;
    logic done_and_next;
    logic draw_and_next;
    logic inter_ready;
    logic interboard_en;
    logic [game_pkg::MSG_W-1:0] interboard_msg_type;
    logic l_click;
    logic mouse_inblock;
    logic [game_pkg::BLOCK_X_W-1:0] mouse_block_x;
    logic [game_pkg::BLOCK_Y_W-1:0] mouse_block_y;
    logic [game_pkg::MAP_W-1:0] map;
    logic can_done;
    logic can_draw;
    logic transmit;
    logic ctrl_en;
    logic ctrl_move_dir;
    logic [game_pkg::BLOCK_X_W-1:0] ctrl_block_x;
    logic [game_pkg::BLOCK_Y_W-1:0] ctrl_block_y;
    logic [game_pkg::MSG_W-1:0] ctrl_msg_type;
    logic [game_pkg::CARD_W-1:0] ctrl_card;
    logic [game_pkg::SEL_LEN_W-1:0] ctrl_sel_len;
    logic [game_pkg::SEL_W-1:0] sel_card;

    // stimulus and expectation table
    int row_kind [NUM_ROWS];
    string row_name [NUM_ROWS];
    int row_x [NUM_ROWS];
    int row_y [NUM_ROWS];
    int row_stall [NUM_ROWS];
    int row_count [NUM_ROWS];
    logic row_can_done [NUM_ROWS];
    logic row_can_draw [NUM_ROWS];
    logic row_transmit [NUM_ROWS];
    logic [game_pkg::SEL_W-1:0] row_sel [NUM_ROWS];
    msg_t row_msgs [NUM_ROWS][MAX_MSGS];
    int num_rows;

    integer seed;
    int row_errors;
    int total_errors;
    int watchdog_ns = 0;

    clock_gen #(.PERIOD_NS(CLK_PERIOD)) u_clock (.clk, .reset_table);

    game_control_top #(.PLAYER(game_pkg::P1)) uut (
        .clk, .reset_table, .start_game, .done_and_next, .draw_and_next, .inter_ready,
        .interboard_en, .interboard_msg_type, .l_click, .mouse_inblock, .mouse_block_x,
        .mouse_block_y, .map, .can_done, .can_draw, .transmit, .ctrl_en, .ctrl_move_dir,
        .ctrl_block_x, .ctrl_block_y, .ctrl_msg_type, .ctrl_card, .ctrl_sel_len, .sel_card
    );

    function automatic int cell_index(input int x, input int y);
        return y * game_pkg::GRID_COLS + x;
    endfunction

    // upper index bits folded into the low ones
    function automatic logic [game_pkg::CARD_W-1:0] card_for_index(input int idx);
        return game_pkg::CARD_W'((idx ^ (idx >> 6)) + 9);
    endfunction

    task automatic add_row(input int kind, input string name, input int x, input int y,
                           input int stall, input logic done_l, input logic draw_l,
                           input logic tx, input logic [game_pkg::SEL_W-1:0] sel);
        row_kind[num_rows] = kind;
        row_name[num_rows] = name;
        row_x[num_rows] = x;
        row_y[num_rows] = y;
        row_stall[num_rows] = stall;
        row_count[num_rows] = 0;
        row_can_done[num_rows] = done_l;
        row_can_draw[num_rows] = draw_l;
        row_transmit[num_rows] = tx;
        row_sel[num_rows] = sel;
        num_rows++;
    endtask

    task automatic add_msg(input logic [game_pkg::MSG_W-1:0] msg_type, input logic dir,
                           input int x, input int y, input logic [game_pkg::CARD_W-1:0] card,
                           input int sel_len);
        msg_t m;
        m.move_dir = dir;
        m.block_x = game_pkg::BLOCK_X_W'(x);
        m.block_y = game_pkg::BLOCK_Y_W'(y);
        m.msg_type = msg_type;
        m.card = card;
        m.sel_len = game_pkg::SEL_LEN_W'(sel_len);
        row_msgs[num_rows-1][row_count[num_rows-1]] = m;
        row_count[num_rows-1]++;
    endtask

    task automatic build_table();
        int x1;
        int y1;
        int x2;
        int y2;
        int i;
        logic [game_pkg::CARD_W-1:0] c1;
        logic [game_pkg::SEL_W-1:0] one_hot;
        x1 = int'($unsigned($random(seed)) % game_pkg::GRID_COLS);
        y1 = int'($unsigned($random(seed)) % game_pkg::GRID_ROWS);
        x2 = int'($unsigned($random(seed)) % game_pkg::GRID_COLS);
        y2 = int'($unsigned($random(seed)) % game_pkg::GRID_ROWS);
        c1 = card_for_index(cell_index(x1, y1));
        one_hot = '0;
        one_hot[cell_index(x1, y1)] = 1'b1;
        num_rows = 0;
        add_row(K_CHECK, "reset", 0, 0, 0, 1'b0, 1'b0, 1'b1, '0);
        add_row(K_START, "start", 0, 0, 0, 1'b0, 1'b0, 1'b1, '0);
        add_msg(game_pkg::MSG_START, 1'b0, 0, 0, '0, 0);
        add_row(K_WAIT, "deal with stalls", 0, 0, 4, 1'b0, 1'b0, 1'b0, '0);
        for (i = 0; i < game_pkg::INIT_HAND_SIZE; i++)
            add_msg(game_pkg::MSG_DRAW, 1'b0, 0, 0, '0, 1);
        add_msg(game_pkg::MSG_STATE_TURN, 1'b0, 0, 0, '0, 0);
        add_row(K_STATE_TURN, "answer state turn", 0, 0, 0, 1'b0, 1'b1, 1'b1, '0);
        add_row(K_CLICK, "take", x1, y1, 2, 1'b0, 1'b0, 1'b1, one_hot);
        add_msg(game_pkg::MSG_TAKE, 1'b0, x1, y1, c1, 1);
        add_row(K_CLICK, "down", x2, y2, 2, 1'b1, 1'b0, 1'b1, '0);
        add_msg(game_pkg::MSG_DOWN, 1'b1, x2, y2, c1, 1);
        add_row(K_DONE, "done", 0, 0, 2, 1'b0, 1'b0, 1'b0, '0);
        add_msg(game_pkg::MSG_DONE, 1'b0, 0, 0, '0, 0);
        add_row(K_OPP_DONE, "opponent done", 0, 0, 0, 1'b0, 1'b1, 1'b1, '0);
        add_row(K_DRAW, "draw", 0, 0, 2, 1'b0, 1'b0, 1'b0, '0);
        add_msg(game_pkg::MSG_DRAW, 1'b0, 0, 0, '0, 1);
        add_msg(game_pkg::MSG_DONE, 1'b0, 0, 0, '0, 0);
        add_row(K_OPP_DONE, "opponent done again", 0, 0, 0, 1'b0, 1'b1, 1'b1, '0);
    endtask

    task automatic report_mismatch(input int r, input string sig,
                                   input logic [VW-1:0] got, input logic [VW-1:0] exp);
        $display("FAIL row %0d: %s got 0x%0h expected 0x%0h", r, sig, got, exp);
        row_errors++;
    endtask

    task automatic apply_action(input int r);
        @(posedge clk);
        case (row_kind[r])
            K_START: start_game <= 1'b1;
            K_STATE_TURN: begin
                interboard_en <= 1'b1;
                interboard_msg_type <= game_pkg::MSG_STATE_TURN;
            end
            K_CLICK: begin
                l_click <= 1'b1;
                mouse_inblock <= 1'b1;
                mouse_block_x <= game_pkg::BLOCK_X_W'(row_x[r]);
                mouse_block_y <= game_pkg::BLOCK_Y_W'(row_y[r]);
            end
            K_DONE: done_and_next <= 1'b1;
            K_DRAW: draw_and_next <= 1'b1;
            K_OPP_DONE: begin
                interboard_en <= 1'b1;
                interboard_msg_type <= game_pkg::MSG_DONE;
            end
            default: ;
        endcase
        @(posedge clk);
        start_game <= 1'b0;
        done_and_next <= 1'b0;
        draw_and_next <= 1'b0;
        l_click <= 1'b0;
        mouse_inblock <= 1'b0;
        interboard_en <= 1'b0;
        interboard_msg_type <= game_pkg::MSG_NONE;
    endtask

    task automatic check_msg(input int r, input int k);
        msg_t e;
        e = row_msgs[r][k];
        if (ctrl_msg_type !== e.msg_type)
            report_mismatch(r, "ctrl_msg_type", VW'(ctrl_msg_type), VW'(e.msg_type));
        if (ctrl_move_dir !== e.move_dir)
            report_mismatch(r, "ctrl_move_dir", VW'(ctrl_move_dir), VW'(e.move_dir));
        if (ctrl_block_x !== e.block_x)
            report_mismatch(r, "ctrl_block_x", VW'(ctrl_block_x), VW'(e.block_x));
        if (ctrl_block_y !== e.block_y)
            report_mismatch(r, "ctrl_block_y", VW'(ctrl_block_y), VW'(e.block_y));
        if (ctrl_card !== e.card)
            report_mismatch(r, "ctrl_card", VW'(ctrl_card), VW'(e.card));
        if (ctrl_sel_len !== e.sel_len)
            report_mismatch(r, "ctrl_sel_len", VW'(ctrl_sel_len), VW'(e.sel_len));
    endtask

    // raises inter_ready with random drops and takes messages in order
    task automatic collect_msgs(input int r);
        int got;
        int idle;
        int stall_left;
        int limit;
        got = 0;
        idle = 0;
        stall_left = 0;
        limit = MSG_BOUND + 2 * row_stall[r];
        while (got < row_count[r] && idle <= limit) begin
            @(posedge clk);
            if (stall_left > 0) begin
                inter_ready <= 1'b0;
                stall_left--;
            end else begin
                inter_ready <= 1'b1;
                if (row_stall[r] > 0 && $unsigned($random(seed)) % 4 == 0)
                    stall_left = 1 + int'($unsigned($random(seed)) % row_stall[r]);
            end
            @(negedge clk);
            if (ctrl_en === 1'b1) begin
                check_msg(r, got);
                got++;
                idle = 0;
            end else begin
                idle++;
            end
        end
        if (got < row_count[r]) begin
            $display("row %0d: message missing, only %0d of %0d arrived", r, got, row_count[r]);
            row_errors++;
        end
        @(posedge clk);
        inter_ready <= 1'b0;
        // nothing more may leave once the row is complete
        repeat (IDLE_CYCLES) begin
            @(negedge clk);
            if (ctrl_en !== 1'b0) begin
                $display("row %0d: extra message of type %0h on ctrl_en", r, ctrl_msg_type);
                row_errors++;
            end
        end
    endtask

    task automatic check_levels(input int r);
        @(negedge clk);
        if (can_done !== row_can_done[r])
            report_mismatch(r, "can_done", VW'(can_done), VW'(row_can_done[r]));
        if (can_draw !== row_can_draw[r])
            report_mismatch(r, "can_draw", VW'(can_draw), VW'(row_can_draw[r]));
        if (transmit !== row_transmit[r])
            report_mismatch(r, "transmit", VW'(transmit), VW'(row_transmit[r]));
        if (sel_card !== row_sel[r])
            report_mismatch(r, "sel_card", sel_card, row_sel[r]);
    endtask

    initial begin
        logic [game_pkg::MAP_W-1:0] map_v;
        int i;
        int cycles;
        int passed;
        int failed;
        for (i = 0; i < game_pkg::SEL_W; i++)
            map_v[i*game_pkg::CARD_W +: game_pkg::CARD_W] = card_for_index(i);
        map <= map_v;
        start_game <= 1'b0;
        done_and_next <= 1'b0;
        draw_and_next <= 1'b0;
        inter_ready <= 1'b0;
        interboard_en <= 1'b0;
        interboard_msg_type <= game_pkg::MSG_NONE;
        l_click <= 1'b0;
        mouse_inblock <= 1'b0;
        mouse_block_x <= '0;
        mouse_block_y <= '0;
        seed = 63863;
        total_errors = 0;
        passed = 0;
        failed = 0;
        build_table();
        // worst case per row is one full gap per expected message
        cycles = 4;
        for (i = 0; i < num_rows; i++)
            cycles += ROW_OVERHEAD + (row_count[i] + 1) * (MSG_BOUND + 2 * row_stall[i] + 1);
        watchdog_ns = cycles * CLK_PERIOD;
        wait (reset_table === 1'b0);
        for (i = 0; i < num_rows; i++) begin
            row_errors = 0;
            apply_action(i);
            collect_msgs(i);
            check_levels(i);
            $display("row %0d %s: %s", i, row_name[i], row_errors == 0 ? "ok" : "mismatch");
            if (row_errors == 0)
                passed++;
            else
                failed++;
            total_errors += row_errors;
        end
        $display("rows %0d, passed %0d, failed %0d, mismatches %0d",
                 num_rows, passed, failed, total_errors);
        if (total_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    initial begin
        wait (watchdog_ns > 0);
        #(watchdog_ns);
        $display("timeout: run still busy after %0d ns", watchdog_ns);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule
